//--- Makefile
TOP := tb_sdram_ctrl

.PHONY: help test clean

help:
	@echo "make test   build with verilator, run the testbench, look for the pass line"
	@echo "make clean  remove the verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sdram_ctrl.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "sim passed"

clean:
	rm -rf obj_dir

//--- sdram_chip_model.sv
`timescale 1ns/10ps
module sdram_chip_model (
    input  logic        clk,
    input  logic        cs_n,
    input  logic        ras_n,
    input  logic        cas_n,
    input  logic        we_n,
    input  logic [12:0] a,
    input  logic        dqml,
    input  logic        dqmh,
    inout  wire  [15:0] dq,
    output int          refresh_cnt
);

    logic [15:0] mem [logic [21:0]];    // sparse storage, unwritten words read as zero
    logic [12:0] mode_reg;
    logic [12:0] open_row;
    logic [3:0]  cmd;
    logic [15:0] dq_out;
    logic        dq_oe;
    logic [15:0] next_word;             // second beat of a burst
    logic        next_valid;

    assign cmd = {cs_n, ras_n, cas_n, we_n};
    assign dq  = dq_oe ? dq_out : 16'hzzzz;

    function automatic logic [15:0] peek(input logic [21:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return 16'h0000;
    endfunction

    initial begin
        mode_reg    = '0;               // no cas latency until the first load
        open_row    = '0;
        dq_out      = '0;
        dq_oe       = 1'b0;
        next_word   = '0;
        next_valid  = 1'b0;
        refresh_cnt = 0;
    end

    always @(posedge clk) begin
        logic [21:0] addr;
        logic [15:0] word;
        addr = {open_row, a[8:0]};
        if (next_valid) begin
            dq_out     <= next_word;    // burst of 2, second word
            next_valid <= 1'b0;
        end else begin
            dq_oe <= 1'b0;              // bus released after the last beat
        end
        case (cmd)
            4'b0000: mode_reg <= a;                     // load mode
            4'b0001: refresh_cnt <= refresh_cnt + 1;    // auto-refresh
            4'b0011: open_row <= a;                     // activate
            4'b0100: begin
                // single-word write, dqm high blocks a byte
                word = peek(addr);
                if (!dqml) begin
                    word[7:0] = dq[7:0];
                end
                if (!dqmh) begin
                    word[15:8] = dq[15:8];
                end
                mem[addr] = word;
            end
            4'b0101: begin
                // cl=2 counted from the controller edge that launched the read
                dq_oe      <= 1'b1;
                dq_out     <= (mode_reg[6:4] == 3'd2) ? peek(addr) : 16'hxxxx;
                next_valid <= (mode_reg[2:0] == 3'd1);
                next_word  <= peek({open_row, a[8:1], ~a[0]}); // sequential, wraps in pair
            end
            default: begin
            end
        endcase
    end

endmodule

//--- sdram_cmd_seq.sv
`timescale 1ns/10ps
module sdram_cmd_seq (
    input  logic                   clk,
    input  logic                   rst,
    input  sdram_pkg::host_req_t   req,
    input  sdram_pkg::sdram_pins_t init_pins,
    input  logic                   init_busy,
    output sdram_pkg::sdram_pins_t pins,
    output sdram_pkg::seq_phase_t  phase,
    output logic                   read_cycle,
    output logic                   mode_ack
);

    sdram_pkg::host_req_t held;             // request parked behind a mode load
    sdram_pkg::host_req_t cur;              // request looked at in phase 0
    logic                 hold;
    logic                 go;
    logic                 park;
    logic                 take;
    logic                 wr_cyc;
    logic                 rf_cyc;
    logic [sdram_pkg::col_w-1:0] col_r;

    assign cur = hold ? held : req;
    assign go  = cur.rd | cur.wr | cur.refresh;

    // a request meeting a mode load is kept for the next phase 0
    assign park = !init_busy && (req.rd | req.wr | req.refresh) &&
                  ((phase == sdram_pkg::ph_idle && req.mode_change) ||
                   phase == sdram_pkg::ph_mode_gap);
    assign take = !init_busy && phase == sdram_pkg::ph_idle && !req.mode_change && go;

    always_ff @(posedge clk) begin
        if (park) begin
            held <= req;
        end
        if (take) begin
            col_r <= cur.addr[sdram_pkg::col_w-1:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pins       <= sdram_pkg::pins_idle;
            phase      <= sdram_pkg::ph_idle;
            read_cycle <= 1'b0;
            wr_cyc     <= 1'b0;
            rf_cyc     <= 1'b0;
            mode_ack   <= 1'b0;
            hold       <= 1'b0;
        end else if (init_busy) begin
            pins <= init_pins;                  // power-up owns the pins
        end else begin
            mode_ack <= 1'b0;
            pins.cmd <= sdram_pkg::cmd_nop;
            if (park) begin
                hold <= 1'b1;
            end else if (take) begin
                hold <= 1'b0;
            end
            case (phase)
                sdram_pkg::ph_idle: begin
                    if (req.mode_change) begin  // mode first, then requests
                        pins.cmd    <= sdram_pkg::cmd_load_mode;
                        pins.a.mode <= sdram_pkg::mode_word(req.burst2);
                        mode_ack    <= 1'b1;
                        phase       <= sdram_pkg::ph_mode_gap;
                    end else if (go) begin
                        pins.cmd   <= (cur.wr | cur.rd) ? sdram_pkg::cmd_activate
                                                        : sdram_pkg::cmd_autorefresh;
                        pins.a     <= cur.addr[sdram_pkg::addr_w-1:sdram_pkg::col_w]; // row
                        pins.dqm   <= cur.wr ? cur.mask : 2'b00;
                        pins.wdata <= cur.data;
                        wr_cyc     <= cur.wr;
                        read_cycle <= cur.rd;
                        rf_cyc     <= cur.refresh;
                        phase      <= phase + 1'b1;
                    end
                end
                sdram_pkg::ph_rw: begin
                    // refresh only needs the nops
                    pins.cmd   <= wr_cyc ? sdram_pkg::cmd_write :
                                  rf_cyc ? sdram_pkg::cmd_nop : sdram_pkg::cmd_read;
                    pins.a.col <= '{unused: 2'b00, auto_precharge: 1'b1, spare: 1'b0,
                                    col: col_r};
                    pins.drive <= wr_cyc;       // bus driven with the write only
                    phase      <= phase + 1'b1;
                end
                sdram_pkg::ph_rw_done: begin
                    pins.drive <= 1'b0;
                    pins.dqm   <= 2'b00;
                    phase      <= phase + 1'b1;
                end
                sdram_pkg::ph_cap_hi, sdram_pkg::ph_mode_gap: begin
                    phase <= sdram_pkg::ph_idle;    // spare nop after a mode load
                end
                default: begin
                    phase <= phase + 1'b1;
                end
            endcase
        end
    end

endmodule

//--- sdram_ctrl.f
sdram_pkg.sv
sdram_req_front.sv
sdram_init_seq.sv
sdram_cmd_seq.sv
sdram_dq_port.sv
sdram_ctrl_top.sv
sdram_chip_model.sv
tb_sdram_ctrl.sv

//--- sdram_ctrl_top.sv
`timescale 1ns/10ps
module sdram_ctrl_top (
    input  logic                          clk,
    input  logic                          rst,
    output logic                          loop_rst,
    input  logic                          read_sync,
    input  logic                          read_req,
    input  logic [sdram_pkg::addr_w-1:0]  sdram_addr,
    output logic [31:0]                   data_read,
    output logic                          data_ok,
    input  logic                          downloading,
    input  logic                          prog_we,
    input  logic [sdram_pkg::addr_w-1:0]  prog_addr,
    input  logic [7:0]                    prog_data,
    input  logic [1:0]                    prog_mask,
    inout  wire  [15:0]                   sdram_dq,
    output logic [sdram_pkg::row_w-1:0]   sdram_a,
    output logic                          sdram_dqml,
    output logic                          sdram_dqmh,
    output logic                          sdram_we_n,
    output logic                          sdram_cas_n,
    output logic                          sdram_ras_n,
    output logic                          sdram_cs_n,
    output logic [1:0]                    sdram_ba,
    output logic                          sdram_cke
);

    sdram_pkg::host_req_t   req;
    sdram_pkg::sdram_pins_t init_pins;
    sdram_pkg::sdram_pins_t pins;
    sdram_pkg::seq_phase_t  phase;
    logic                   init_busy;
    logic                   read_cycle;
    logic                   mode_ack;

    sdram_req_front u_front (
        .clk, .rst, .read_sync, .read_req, .sdram_addr, .downloading,
        .prog_we, .prog_addr, .prog_data, .prog_mask, .mode_ack, .req
    );

    sdram_init_seq u_init (.clk, .rst, .pins(init_pins), .busy(init_busy));

    sdram_cmd_seq u_seq (
        .clk, .rst, .req, .init_pins, .init_busy,
        .pins, .phase, .read_cycle, .mode_ack
    );

    sdram_dq_port u_dq (
        .clk, .rst, .pins, .phase, .read_cycle, .sdram_dq, .data_read, .data_ok
    );

    assign loop_rst = init_busy;    // host core held until init is done

    assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = pins.cmd;
    assign sdram_a    = pins.a;
    assign sdram_dqml = pins.dqm[0];
    assign sdram_dqmh = pins.dqm[1];
    assign sdram_ba   = 2'b00;      // bank 0 only
    assign sdram_cke  = 1'b1;

endmodule

//--- sdram_dq_port.sv
`timescale 1ns/10ps
module sdram_dq_port (
    input  logic                   clk,
    input  logic                   rst,
    input  sdram_pkg::sdram_pins_t pins,
    input  sdram_pkg::seq_phase_t  phase,
    input  logic                   read_cycle,
    inout  wire  [15:0]            sdram_dq,
    output logic [31:0]            data_read,
    output logic                   data_ok
);

    // write byte goes out on both halves, dqm picks the lane
    assign sdram_dq = pins.drive ? {pins.wdata, pins.wdata} : 16'hzzzz;

    always_ff @(posedge clk) begin
        if (read_cycle) begin
            if (phase == sdram_pkg::ph_cap_lo) begin
                data_read[31:16] <= sdram_dq;           // first word
            end else if (phase == sdram_pkg::ph_cap_hi) begin
                data_read[15:0]  <= data_read[31:16];   // first word moves down
                data_read[31:16] <= sdram_dq;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= read_cycle && phase == sdram_pkg::ph_cap_hi; // one cycle
        end
    end

endmodule

//--- sdram_init_seq.sv
`timescale 1ns/10ps
module sdram_init_seq (
    input  logic                   clk,
    input  logic                   rst,
    output sdram_pkg::sdram_pins_t pins,
    output logic                   busy
);

    sdram_pkg::init_cnt_t wait_cnt;     // cycles left in current step
    logic [2:0]           step;
    logic [3:0]           next_cmd;     // goes out on the next wait cycle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pins     <= sdram_pkg::pins_idle;
            wait_cnt <= sdram_pkg::init_wait_load;
            step     <= 3'd0;
            next_cmd <= sdram_pkg::cmd_nop;
            busy     <= 1'b1;
        end else if (busy) begin
            if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
                pins.cmd <= next_cmd;           // staged command, then nop
                next_cmd <= sdram_pkg::cmd_nop;
            end else begin
                if (!step[2]) begin
                    step <= step + 3'd1;
                end
                case (step)
                    3'd0, 3'd3: begin           // precharge all, before and after mode
                        next_cmd <= sdram_pkg::cmd_precharge;
                        pins.a   <= sdram_pkg::a_prech_all;
                        wait_cnt <= sdram_pkg::prech_wait;
                    end
                    3'd1: begin
                        next_cmd <= sdram_pkg::cmd_autorefresh;
                        wait_cnt <= sdram_pkg::ref_wait;
                    end
                    3'd2: begin
                        // cl=2, single word until downloading ends
                        next_cmd    <= sdram_pkg::cmd_load_mode;
                        pins.a.mode <= sdram_pkg::mode_word(1'b0);
                        wait_cnt    <= sdram_pkg::mode_wait;
                    end
                    default: begin
                        busy <= 1'b0;           // hand the pins over
                    end
                endcase
            end
        end
    end

endmodule

//--- sdram_pkg.sv
package sdram_pkg;

    // host word address splits into row and column
    localparam int addr_w = 22;
    localparam int row_w  = 13;
    localparam int col_w  = 9;

    localparam int init_wait_cycles = 9750;                     // ~100us at 96MHz
    localparam int init_cnt_w       = $clog2(init_wait_cycles + 1);
    localparam int cas_latency      = 2;

    typedef logic [init_cnt_w-1:0] init_cnt_t;

    // power-up waits, loaded after each init command is staged
    localparam init_cnt_t init_wait_load = init_cnt_t'(init_wait_cycles);
    localparam init_cnt_t prech_wait     = init_cnt_t'(2);
    localparam init_cnt_t ref_wait       = init_cnt_t'(11);
    localparam init_cnt_t mode_wait      = init_cnt_t'(3);

    // {cs_n, ras_n, cas_n, we_n}
    localparam logic [3:0] cmd_load_mode   = 4'b0000;
    localparam logic [3:0] cmd_autorefresh = 4'b0001;
    localparam logic [3:0] cmd_precharge   = 4'b0010;
    localparam logic [3:0] cmd_activate    = 4'b0011;
    localparam logic [3:0] cmd_write       = 4'b0100;
    localparam logic [3:0] cmd_read        = 4'b0101;
    localparam logic [3:0] cmd_nop         = 4'b0111;

    localparam logic [row_w-1:0] a_prech_all = 13'h0400;       // a10 selects all banks

    typedef struct packed {
        logic [2:0] reserved;
        logic       write_burst_single;
        logic [1:0] op_mode;
        logic [2:0] cas_lat;
        logic       burst_type;                                 // 0 = sequential
        logic [2:0] burst_len;                                  // 000 = 1, 001 = 2
    } mode_reg_t;

    typedef struct packed {
        logic [1:0]       unused;
        logic             auto_precharge;                       // a10
        logic             spare;
        logic [col_w-1:0] col;
    } col_word_t;

    // same 13 address pins, read as mode word or as column word
    typedef union packed {
        mode_reg_t mode;
        col_word_t col;
    } sdram_a_t;

    typedef struct packed {
        logic [3:0] cmd;
        sdram_a_t   a;
        logic [1:0] dqm;                                        // [1] upper byte
        logic       drive;                                      // controller owns dq
        logic [7:0] wdata;
    } sdram_pins_t;

    typedef struct packed {
        logic              rd;
        logic              refresh;
        logic              wr;
        logic              mode_change;
        logic              burst2;
        logic [addr_w-1:0] addr;
        logic [7:0]        data;
        logic [1:0]        mask;
    } host_req_t;

    typedef logic [2:0] seq_phase_t;

    localparam seq_phase_t ph_idle     = 3'd0;
    localparam seq_phase_t ph_rw       = 3'd2;
    localparam seq_phase_t ph_rw_done  = 3'd3;
    localparam seq_phase_t ph_cap_lo   = 3'd4;
    localparam seq_phase_t ph_cap_hi   = 3'd5;
    localparam seq_phase_t ph_mode_gap = 3'd7;

    localparam sdram_pins_t pins_idle = '{cmd: cmd_nop, a: '0, dqm: 2'b00,
                                          drive: 1'b0, wdata: 8'h00};

    // cl=2, sequential, single-word writes
    function automatic mode_reg_t mode_word(input logic burst2);
        mode_reg_t m;
        m = '0;
        m.write_burst_single = 1'b1;
        m.cas_lat            = 3'(cas_latency);
        m.burst_len          = {2'b00, burst2};
        return m;
    endfunction

endpackage

//--- sdram_req_front.sv
`timescale 1ns/10ps
module sdram_req_front (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          read_sync,
    input  logic                          read_req,
    input  logic [sdram_pkg::addr_w-1:0]  sdram_addr,
    input  logic                          downloading,
    input  logic                          prog_we,
    input  logic [sdram_pkg::addr_w-1:0]  prog_addr,
    input  logic [7:0]                    prog_data,
    input  logic [1:0]                    prog_mask,
    input  logic                          mode_ack,
    output sdram_pkg::host_req_t          req
);

    logic sync_q;                                   // sampled read_sync
    logic sync_last;                                // previous sample, for toggle
    logic want_q;                                   // host wants data
    logic dl_q;                                     // delayed downloading
    logic dl_last;
    logic we_q;
    logic toggle;

    logic [sdram_pkg::addr_w-1:0] rd_addr_q;
    logic [sdram_pkg::addr_w-1:0] wr_addr_q;
    logic [7:0]                   data_q;
    logic [1:0]                   mask_q;

    // request register
    logic                         rd_r;
    logic                         rf_r;
    logic                         wr_r;
    logic                         mc_r;
    logic                         b2_r;
    logic [sdram_pkg::addr_w-1:0] addr_r;
    logic [7:0]                   data_r;
    logic [1:0]                   mask_r;

    assign toggle = sync_q != sync_last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_q    <= 1'b0;
            sync_last <= 1'b0;
            want_q    <= 1'b0;
            dl_q      <= 1'b0;
            dl_last   <= 1'b0;
            we_q      <= 1'b0;
            rd_r      <= 1'b0;
            rf_r      <= 1'b0;
            wr_r      <= 1'b0;
            mc_r      <= 1'b0;
            b2_r      <= 1'b0;              // power-up mode is burst of 1
        end else begin
            sync_q    <= read_sync;
            sync_last <= sync_q;
            want_q    <= read_req;
            dl_q      <= downloading;
            dl_last   <= dl_q;
            we_q      <= prog_we;
            rd_r      <= ~dl_q & toggle & want_q;
            rf_r      <= ~dl_q & toggle & ~want_q;  // no data wanted, refresh instead
            wr_r      <= dl_q & we_q;
            if (dl_q != dl_last) begin      // either edge asks for a new mode
                mc_r <= 1'b1;
                b2_r <= ~dl_q;
            end else if (mode_ack) begin
                mc_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_addr_q <= sdram_addr;
        wr_addr_q <= prog_addr;
        data_q    <= prog_data;
        mask_q    <= prog_mask;
        addr_r    <= dl_q ? wr_addr_q : rd_addr_q;  // one address field for both paths
        data_r    <= data_q;
        mask_r    <= mask_q;
    end

    assign req = '{rd: rd_r, refresh: rf_r, wr: wr_r, mode_change: mc_r, burst2: b2_r,
                   addr: addr_r, data: data_r, mask: mask_r};

endmodule

//--- tb_sdram_ctrl.sv
`timescale 1ns/10ps
module tb_sdram_ctrl;

    // {cs_n, ras_n, cas_n, we_n} as in the sdram datasheet
    localparam logic [3:0] c_load  = 4'b0000;
    localparam logic [3:0] c_ref   = 4'b0001;
    localparam logic [3:0] c_prech = 4'b0010;
    localparam logic [3:0] c_act   = 4'b0011;
    localparam logic [3:0] c_write = 4'b0100;
    localparam logic [3:0] c_read  = 4'b0101;
    localparam logic [3:0] c_nop   = 4'b0111;

    localparam int n_writes   = 64;
    localparam int n_reads    = 100;
    localparam int n_refresh  = 30;
    localparam int n_requests = n_writes + n_reads + 2 * n_refresh + 4; // read after each refresh
    localparam int max_cycles = 2 * (sdram_pkg::init_wait_cycles + 20 + 12 * n_requests);

    logic        clk;
    logic        rst;
    logic        read_sync;
    logic        read_req;
    logic [21:0] sdram_addr;
    logic        downloading;
    logic        prog_we;
    logic [21:0] prog_addr;
    logic [7:0]  prog_data;
    logic [1:0]  prog_mask;
    logic        loop_rst;
    logic [31:0] data_read;
    logic        data_ok;
    wire  [15:0] sdram_dq;
    logic [12:0] sdram_a;
    logic        dqml;
    logic        dqmh;
    logic        we_n;
    logic        cas_n;
    logic        ras_n;
    logic        cs_n;
    logic [1:0]  ba;
    logic        cke;
    logic [3:0]  bus_cmd;
    int          refresh_cnt;

    logic [21:0] exp_addr;              // set by stimulus, row/col the monitor expects
    logic [2:0]  exp_burst;
    int          mode_req = 0;          // downloading edges driven
    int          mode_seen = 0;         // mode loads seen on the bus
    int          init_loads = 0;
    int          act_seen = 0;
    int          wr_seen = 0;
    int          cycles = 0;

    logic [15:0] ref_mem [logic [21:0]];
    logic [21:0] written [$];
    logic [12:0] rows [2];              // download lands in two rows

    sdram_ctrl_top uut (
        .clk, .rst, .loop_rst, .read_sync, .read_req, .sdram_addr, .data_read, .data_ok,
        .downloading, .prog_we, .prog_addr, .prog_data, .prog_mask, .sdram_dq, .sdram_a,
        .sdram_dqml(dqml), .sdram_dqmh(dqmh), .sdram_we_n(we_n), .sdram_cas_n(cas_n),
        .sdram_ras_n(ras_n), .sdram_cs_n(cs_n), .sdram_ba(ba), .sdram_cke(cke)
    );

    sdram_chip_model u_chip (
        .clk, .cs_n, .ras_n, .cas_n, .we_n, .a(sdram_a), .dqml, .dqmh, .dq(sdram_dq),
        .refresh_cnt
    );

    assign bus_cmd = {cs_n, ras_n, cas_n, we_n};

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] t=%0t %s got 0x%0h expected 0x%0h",
                                $time, name, got, exp));
        end
    endtask

    function automatic logic [15:0] ref_word(input logic [21:0] addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return 16'h0000;                // chip model fills with zero
    endfunction

    function automatic logic [21:0] pick_read_addr();
        if ($urandom % 2 == 0) begin
            return written[$urandom % written.size()];  // hit downloaded data
        end
        return 22'($urandom);
    endfunction

    task automatic step_clock();
        @(posedge clk);
        #1;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            abort_run($sformatf("timeout, test still running after %0d cycles", max_cycles));
        end
    end

    // bus monitor, pins are stable mid-cycle
    always @(negedge clk) begin
        if (!rst && loop_rst) begin
            check_value("init command legal",
                        32'(bus_cmd inside {c_nop, c_prech, c_ref, c_load}), 1);
            if (bus_cmd == c_load) begin
                check_value("init mode cas latency", 32'(sdram_a[6:4]), 2);
                init_loads++;
            end
        end else if (!rst) begin
            if (mode_req != mode_seen && bus_cmd != c_nop) begin
                check_value("command after downloading edge", 32'(bus_cmd), 32'(c_load));
                check_value("mode burst length", 32'(sdram_a[2:0]), 32'(exp_burst));
                mode_seen++;
            end else if (bus_cmd == c_act) begin
                check_value("activate row", 32'(sdram_a), 32'(exp_addr[21:9]));
                act_seen++;
            end else if (bus_cmd == c_read || bus_cmd == c_write) begin
                check_value("access column", 32'(sdram_a[8:0]), 32'(exp_addr[8:0]));
                check_value("auto precharge a10", 32'(sdram_a[10]), 1);
                if (bus_cmd == c_write) begin
                    wr_seen++;
                end
            end
        end
    end

    task automatic set_download(input logic level);
        step_clock();
        downloading = level;
        exp_burst   = level ? 3'd0 : 3'd1;  // burst of 2 only for playback
        mode_req++;
        repeat (8) @(posedge clk);
        check_value("mode loads seen", mode_seen, mode_req);
    endtask

    task automatic download_write(input logic [21:0] addr, input logic [7:0] data,
                                  input logic [1:0] mask);
        logic [15:0] word;
        word = ref_word(addr);
        if (!mask[0]) begin
            word[7:0] = data;
        end
        if (!mask[1]) begin
            word[15:8] = data;
        end
        ref_mem[addr] = word;
        written.push_back(addr);
        step_clock();
        exp_addr  = addr;
        prog_addr = addr;
        prog_data = data;
        prog_mask = mask;
        prog_we   = 1'b1;
        step_clock();
        prog_we = 1'b0;
        repeat (8) @(posedge clk);      // pulses 10 cycles apart
    endtask

    task automatic read_check(input logic [21:0] addr, input logic end_dl);
        int          n;
        logic        seen;
        logic [31:0] expect_data;
        expect_data = {ref_word({addr[21:1], ~addr[0]}), ref_word(addr)};
        step_clock();
        exp_addr   = addr;
        sdram_addr = addr;
        read_req   = 1'b1;
        read_sync  = ~read_sync;
        if (end_dl) begin
            downloading = 1'b0;         // mode load goes first, 2 cycles later
            exp_burst   = 3'd1;
            mode_req++;
        end
        n    = 0;
        seen = 1'b0;
        while (!seen && n < 30) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            seen = data_ok;
        end
        if (!seen) begin
            abort_run("read was never answered with data_ok");
        end
        check_value("data_ok latency", n, end_dl ? 10 : 8);
        check_value("data_read", data_read, expect_data);
        @(negedge clk);
        check_value("data_ok after pulse", 32'(data_ok), 0);
        repeat (2) @(posedge clk);
    endtask

    task automatic refresh_check(input int idx, input int base);
        step_clock();
        read_req   = 1'b0;              // toggle without data wanted
        sdram_addr = 22'($urandom);
        read_sync  = ~read_sync;
        repeat (10) begin
            @(negedge clk);
            check_value("data_ok on refresh", 32'(data_ok), 0);
        end
        check_value("chip refresh count", refresh_cnt, base + idx + 1);
    endtask

    initial begin
        int base;
        void'($urandom(32'h58bf));
        rst         = 1'b1;
        read_sync   = 1'b0;
        read_req    = 1'b0;
        sdram_addr  = '0;
        downloading = 1'b0;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        prog_mask   = '0;
        exp_addr    = '0;
        exp_burst   = 3'd0;
        rows[0]     = 13'($urandom);
        rows[1]     = 13'($urandom);
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        while (loop_rst) begin
            @(posedge clk);
        end
        @(negedge clk);
        check_value("init load mode count", init_loads, 1);
        check_value("init refresh count", refresh_cnt, 1);
        check_value("sdram_cke", 32'(cke), 1);
        check_value("sdram_ba", 32'(ba), 0);

        set_download(1'b1);
        for (int i = 0; i < n_writes; i++) begin
            download_write({rows[$urandom % 2], 9'($urandom % 48)}, 8'($urandom),
                           2'($urandom));
        end
        check_value("activates in download", act_seen, n_writes);
        check_value("writes in download", wr_seen, n_writes);

        // first read meets the burst-of-2 load
        read_check(written[0], 1'b1);
        for (int i = 1; i < n_reads; i++) begin
            read_check(pick_read_addr(), 1'b0);
        end

        base = refresh_cnt;
        for (int i = 0; i < n_refresh; i++) begin
            refresh_check(i, base);
            read_check(written[$urandom % written.size()], 1'b0);
        end

        set_download(1'b1);             // back to burst of 1
        set_download(1'b0);
        read_check(written[$], 1'b0);

        $display("sim passed");
        $finish;
    end

endmodule
